//--- include/ct_fspu_params.svh
`ifndef CT_FSPU_PARAMS_SVH
`define CT_FSPU_PARAMS_SVH

// Operand word and its IEEE single fields
`define FSPU_XLEN         32
`define FSPU_EXP_W        8
`define FSPU_MAN_W        23

// Issue word widths
`define FSPU_OP_W         3
`define FSPU_SEL_W        3

// Operation codes
`define FSPU_OP_SGNJ      3'd0
`define FSPU_OP_SGNJN     3'd1
`define FSPU_OP_SGNJX     3'd2
`define FSPU_OP_CLASS     3'd3
`define FSPU_OP_MV        3'd4

// Classification mask, one bit per class
`define FSPU_CLS_W        10
`define FSPU_CLS_NEG_INF  0
`define FSPU_CLS_NEG_NORM 1
`define FSPU_CLS_NEG_SUB  2
`define FSPU_CLS_NEG_ZERO 3
`define FSPU_CLS_POS_ZERO 4
`define FSPU_CLS_POS_SUB  5
`define FSPU_CLS_POS_NORM 6
`define FSPU_CLS_POS_INF  7
`define FSPU_CLS_SNAN     8
`define FSPU_CLS_QNAN     9

`endif

//--- source/ct_fspu_pkg.sv
`default_nettype none

`include "ct_fspu_params.svh"

package ct_fspu_pkg;

  // Operand or result word
  typedef logic [`FSPU_XLEN-1:0]  fspu_data_t;

  // Operation code from the issue stage
  typedef logic [`FSPU_OP_W-1:0]  fspu_op_t;

  // Pipe select word
  // Bit 0 is this pipe, upper bits go to sibling pipes
  typedef logic [`FSPU_SEL_W-1:0] fspu_pipe_sel_t;

  // One-hot classification mask
  typedef logic [`FSPU_CLS_W-1:0] fspu_class_t;

  // Biased exponent field
  typedef logic [`FSPU_EXP_W-1:0] fspu_exp_t;

  // Mantissa field without hidden bit
  typedef logic [`FSPU_MAN_W-1:0] fspu_man_t;

endpackage

`default_nettype wire

//--- source/gated_clk_cell.sv
`default_nettype none

module gated_clk_cell (
  input  logic clk_in,
  input  logic global_en,
  input  logic module_en,
  input  logic local_en,
  input  logic pad_yy_icg_scan_en,
  output logic clk_out
);

  logic clk_en;
  logic clk_en_lat;

  // Global enable qualifies both module and local requests
  // Scan enable overrides everything
  assign clk_en = (global_en & (module_en | local_en)) | pad_yy_icg_scan_en;

  // Latch open in the low phase so the enable is stable while clk_in is high
  always_latch
  begin
    if (!clk_in)
      clk_en_lat = clk_en;
  end

  // Glitch free gated clock
  assign clk_out = clk_in & clk_en_lat;

endmodule

`default_nettype wire

//--- source/ct_fspu_ctrl.sv
`default_nettype none

module ct_fspu_ctrl (
  input  logic                        ex1_vld_clk,
  input  logic                        cpurst_b,
  input  logic                        cp0_yy_clk_en,
  input  logic                        cp0_vfpu_icg_en,
  input  logic                        pad_yy_icg_scan_en,
  input  ct_fspu_pkg::fspu_pipe_sel_t dp_vfalu_ex1_pipex_sel,
  output logic                        ex1_pipedown,
  output logic                        ex2_pipedown,
  output logic                        ex3_pipedown
);

  logic ex2_stage_clk;
  logic ex2_stage_clk_en;
  logic ex3_stage_clk;
  logic ex3_stage_clk_en;

  // EX1 level
  // Only bit 0 targets this pipe
  assign ex1_pipedown = dp_vfalu_ex1_pipex_sel[0];

  // EX2 stage clock
  // Runs while work enters or sits in EX2
  assign ex2_stage_clk_en = ex1_pipedown | ex2_pipedown;

  gated_clk_cell x_ex2_stage_clk (
    .clk_in             (ex1_vld_clk),
    .global_en          (cp0_yy_clk_en),
    .module_en          (cp0_vfpu_icg_en),
    .local_en           (ex2_stage_clk_en),
    .pad_yy_icg_scan_en (pad_yy_icg_scan_en),
    .clk_out            (ex2_stage_clk)
  );

  // EX2 level follows EX1 one edge later
  always_ff @(posedge ex2_stage_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      ex2_pipedown <= 1'b0;
    else
      ex2_pipedown <= ex1_pipedown;
  end

  // EX3 stage clock
  // Extra edge after EX2 empties clears the EX3 level
  assign ex3_stage_clk_en = ex2_pipedown | ex3_pipedown;

  gated_clk_cell x_ex3_stage_clk (
    .clk_in             (ex1_vld_clk),
    .global_en          (cp0_yy_clk_en),
    .module_en          (cp0_vfpu_icg_en),
    .local_en           (ex3_stage_clk_en),
    .pad_yy_icg_scan_en (pad_yy_icg_scan_en),
    .clk_out            (ex3_stage_clk)
  );

  // EX3 level is the result valid
  always_ff @(posedge ex3_stage_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      ex3_pipedown <= 1'b0;
    else
      ex3_pipedown <= ex2_pipedown;
  end

endmodule

`default_nettype wire

//--- source/ct_fspu_dp.sv
`default_nettype none

`include "ct_fspu_params.svh"

module ct_fspu_dp (
  input  logic                    ex1_vld_clk,
  input  logic                    cpurst_b,
  input  logic                    cp0_yy_clk_en,
  input  logic                    cp0_vfpu_icg_en,
  input  logic                    pad_yy_icg_scan_en,
  input  logic                    ex1_pipedown,
  input  logic                    ex2_pipedown,
  input  ct_fspu_pkg::fspu_op_t   dp_vfalu_ex1_op,
  input  ct_fspu_pkg::fspu_data_t dp_vfalu_ex1_src0,
  input  ct_fspu_pkg::fspu_data_t dp_vfalu_ex1_src1,
  output ct_fspu_pkg::fspu_data_t fspu_ex3_result
);

  // EX1 operand fields
  logic                     ex1_src0_sign;
  logic                     ex1_src1_sign;
  logic [`FSPU_XLEN-2:0]    ex1_src0_body;
  ct_fspu_pkg::fspu_exp_t   ex1_src0_exp;
  ct_fspu_pkg::fspu_man_t   ex1_src0_man;

  // EX1 field decode
  logic                     ex1_exp_zero;
  logic                     ex1_exp_max;
  logic                     ex1_man_zero;
  logic                     ex1_is_zero;
  logic                     ex1_is_sub;
  logic                     ex1_is_norm;
  logic                     ex1_is_inf;
  logic                     ex1_is_nan;
  logic                     ex1_is_qnan;
  logic                     ex1_is_snan;

  // EX1 results
  ct_fspu_pkg::fspu_class_t ex1_class;
  ct_fspu_pkg::fspu_data_t  ex1_result;

  // Later stages
  logic                     ex2_data_clk;
  logic                     ex3_data_clk;
  ct_fspu_pkg::fspu_data_t  ex2_result;

  // Split operands
  assign ex1_src0_sign = dp_vfalu_ex1_src0[`FSPU_XLEN-1];
  assign ex1_src1_sign = dp_vfalu_ex1_src1[`FSPU_XLEN-1];
  assign ex1_src0_body = dp_vfalu_ex1_src0[`FSPU_XLEN-2:0];
  assign ex1_src0_exp  = dp_vfalu_ex1_src0[`FSPU_XLEN-2 -: `FSPU_EXP_W];
  assign ex1_src0_man  = dp_vfalu_ex1_src0[`FSPU_MAN_W-1:0];

  // Exponent and mantissa extremes
  assign ex1_exp_zero = ~|ex1_src0_exp;
  assign ex1_exp_max  = &ex1_src0_exp;
  assign ex1_man_zero = ~|ex1_src0_man;

  // Number classes
  assign ex1_is_zero = ex1_exp_zero & ex1_man_zero;
  assign ex1_is_sub  = ex1_exp_zero & ~ex1_man_zero;
  assign ex1_is_norm = ~ex1_exp_zero & ~ex1_exp_max;
  assign ex1_is_inf  = ex1_exp_max & ex1_man_zero;
  assign ex1_is_nan  = ex1_exp_max & ~ex1_man_zero;

  // Mantissa MSB tells quiet from signaling NaN
  assign ex1_is_qnan = ex1_is_nan & ex1_src0_man[`FSPU_MAN_W-1];
  assign ex1_is_snan = ex1_is_nan & ~ex1_src0_man[`FSPU_MAN_W-1];

  // One-hot class mask
  // NaN bits ignore the sign
  always_comb
  begin
    ex1_class                          = '0;
    ex1_class[`FSPU_CLS_NEG_INF]       = ex1_src0_sign & ex1_is_inf;
    ex1_class[`FSPU_CLS_NEG_NORM]      = ex1_src0_sign & ex1_is_norm;
    ex1_class[`FSPU_CLS_NEG_SUB]       = ex1_src0_sign & ex1_is_sub;
    ex1_class[`FSPU_CLS_NEG_ZERO]      = ex1_src0_sign & ex1_is_zero;
    ex1_class[`FSPU_CLS_POS_ZERO]      = ~ex1_src0_sign & ex1_is_zero;
    ex1_class[`FSPU_CLS_POS_SUB]       = ~ex1_src0_sign & ex1_is_sub;
    ex1_class[`FSPU_CLS_POS_NORM]      = ~ex1_src0_sign & ex1_is_norm;
    ex1_class[`FSPU_CLS_POS_INF]       = ~ex1_src0_sign & ex1_is_inf;
    ex1_class[`FSPU_CLS_SNAN]          = ex1_is_snan;
    ex1_class[`FSPU_CLS_QNAN]          = ex1_is_qnan;
  end

  // Result select by operation
  // Sign injection keeps the body of src0 untouched, NaN payload included
  always_comb
  begin
    case (dp_vfalu_ex1_op)
      `FSPU_OP_SGNJ:
        ex1_result = {ex1_src1_sign, ex1_src0_body};
      `FSPU_OP_SGNJN:
        ex1_result = {~ex1_src1_sign, ex1_src0_body};
      `FSPU_OP_SGNJX:
        ex1_result = {ex1_src0_sign ^ ex1_src1_sign, ex1_src0_body};
      `FSPU_OP_CLASS:
        ex1_result = {{(`FSPU_XLEN-`FSPU_CLS_W){1'b0}}, ex1_class};
      `FSPU_OP_MV:
        ex1_result = dp_vfalu_ex1_src0;
      // Unused codes give zero
      default:
        ex1_result = '0;
    endcase
  end

  // EX2 data clock
  // Only ticks when EX1 holds a selected issue
  gated_clk_cell x_ex2_data_clk (
    .clk_in             (ex1_vld_clk),
    .global_en          (cp0_yy_clk_en),
    .module_en          (cp0_vfpu_icg_en),
    .local_en           (ex1_pipedown),
    .pad_yy_icg_scan_en (pad_yy_icg_scan_en),
    .clk_out            (ex2_data_clk)
  );

  // EX2 result register
  // Load qualifier still needed when clocks are forced on
  always_ff @(posedge ex2_data_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      ex2_result <= '0;
    else if (ex1_pipedown)
      ex2_result <= ex1_result;
  end

  // EX3 data clock
  gated_clk_cell x_ex3_data_clk (
    .clk_in             (ex1_vld_clk),
    .global_en          (cp0_yy_clk_en),
    .module_en          (cp0_vfpu_icg_en),
    .local_en           (ex2_pipedown),
    .pad_yy_icg_scan_en (pad_yy_icg_scan_en),
    .clk_out            (ex3_data_clk)
  );

  // EX3 result register
  // Held between results
  always_ff @(posedge ex3_data_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      fspu_ex3_result <= '0;
    else if (ex2_pipedown)
      fspu_ex3_result <= ex2_result;
  end

endmodule

`default_nettype wire

//--- source/ct_fspu_top.sv
`default_nettype none

module ct_fspu_top (
  input  logic                        ex1_vld_clk,
  input  logic                        cpurst_b,
  input  logic                        cp0_yy_clk_en,
  input  logic                        cp0_vfpu_icg_en,
  input  logic                        pad_yy_icg_scan_en,
  input  ct_fspu_pkg::fspu_pipe_sel_t dp_vfalu_ex1_pipex_sel,
  input  ct_fspu_pkg::fspu_op_t       dp_vfalu_ex1_op,
  input  ct_fspu_pkg::fspu_data_t     dp_vfalu_ex1_src0,
  input  ct_fspu_pkg::fspu_data_t     dp_vfalu_ex1_src1,
  output logic                        ex3_pipedown,
  output ct_fspu_pkg::fspu_data_t     fspu_ex3_result
);

  // Stage levels from control to datapath
  logic ex1_pipedown;
  logic ex2_pipedown;

  // Pipedown control
  ct_fspu_ctrl x_ct_fspu_ctrl (
    .ex1_vld_clk            (ex1_vld_clk),
    .cpurst_b               (cpurst_b),
    .cp0_yy_clk_en          (cp0_yy_clk_en),
    .cp0_vfpu_icg_en        (cp0_vfpu_icg_en),
    .pad_yy_icg_scan_en     (pad_yy_icg_scan_en),
    .dp_vfalu_ex1_pipex_sel (dp_vfalu_ex1_pipex_sel),
    .ex1_pipedown           (ex1_pipedown),
    .ex2_pipedown           (ex2_pipedown),
    .ex3_pipedown           (ex3_pipedown)
  );

  // Sign inject, classify and move datapath
  ct_fspu_dp x_ct_fspu_dp (
    .ex1_vld_clk        (ex1_vld_clk),
    .cpurst_b           (cpurst_b),
    .cp0_yy_clk_en      (cp0_yy_clk_en),
    .cp0_vfpu_icg_en    (cp0_vfpu_icg_en),
    .pad_yy_icg_scan_en (pad_yy_icg_scan_en),
    .ex1_pipedown       (ex1_pipedown),
    .ex2_pipedown       (ex2_pipedown),
    .dp_vfalu_ex1_op    (dp_vfalu_ex1_op),
    .dp_vfalu_ex1_src0  (dp_vfalu_ex1_src0),
    .dp_vfalu_ex1_src1  (dp_vfalu_ex1_src1),
    .fspu_ex3_result    (fspu_ex3_result)
  );

endmodule

`default_nettype wire

//--- verification/ct_fspu_properties.sv
`default_nettype none

module ct_fspu_properties (
  input logic                    ex1_vld_clk,
  input logic                    cpurst_b,
  input logic                    ex1_pipedown,
  input logic                    ex2_pipedown,
  input logic                    ex3_pipedown,
  input ct_fspu_pkg::fspu_data_t fspu_ex3_result
);

  // Running count of property failures
  int unsigned prop_errs = 0;

  // EX2 level is EX1 one edge later
  ex2_follows_ex1: assert property (
    @(posedge ex1_vld_clk) disable iff (!cpurst_b)
    ex2_pipedown == $past(ex1_pipedown)
  )
  else
  begin
    prop_errs++;
    $error("ex2_pipedown does not follow ex1_pipedown by one cycle");
  end

  // EX3 level is EX2 one edge later
  ex3_follows_ex2: assert property (
    @(posedge ex1_vld_clk) disable iff (!cpurst_b)
    ex3_pipedown == $past(ex2_pipedown)
  )
  else
  begin
    prop_errs++;
    $error("ex3_pipedown does not follow ex2_pipedown by one cycle");
  end

  // Pipe empty right after reset release
  levels_low_after_reset: assert property (
    @(posedge ex1_vld_clk)
    $rose(cpurst_b) |-> (!ex2_pipedown && !ex3_pipedown)
  )
  else
  begin
    prop_errs++;
    $error("Pipedown levels not low in the first cycle after reset");
  end

  // Presented result fully known
  result_known: assert property (
    @(posedge ex1_vld_clk) disable iff (!cpurst_b)
    ex3_pipedown |-> !$isunknown(fspu_ex3_result)
  )
  else
  begin
    prop_errs++;
    $error("Result has unknown bits while ex3_pipedown is high");
  end

endmodule

`default_nettype wire

//--- verification/ct_fspu_tb.sv
`default_nettype none

`include "ct_fspu_params.svh"

module ct_fspu_tb;

  localparam int MAX_VECS  = 64;
  // Words per vector: sel, op, src0, src1, expected
  localparam int VEC_WORDS = 5;
  localparam int LATENCY   = 2;

  // DUT inputs
  logic                        ex1_vld_clk;
  logic                        cpurst_b;
  logic                        cp0_yy_clk_en;
  logic                        cp0_vfpu_icg_en;
  logic                        pad_yy_icg_scan_en;
  ct_fspu_pkg::fspu_pipe_sel_t dp_vfalu_ex1_pipex_sel;
  ct_fspu_pkg::fspu_op_t       dp_vfalu_ex1_op;
  ct_fspu_pkg::fspu_data_t     dp_vfalu_ex1_src0;
  ct_fspu_pkg::fspu_data_t     dp_vfalu_ex1_src1;

  // DUT outputs
  logic                        ex3_pipedown;
  ct_fspu_pkg::fspu_data_t     fspu_ex3_result;

  // Vector storage
  logic [31:0]                 vec_mem [0:MAX_VECS*VEC_WORDS-1];
  int                          vec_cnt;
  bit                          vec_loaded = 1'b0;

  // Scoreboard queues, one entry per selected issue
  ct_fspu_pkg::fspu_data_t     exp_q[$];
  string                       name_q[$];
  int                          cyc_q[$];

  int                          cycle = 0;
  int                          value_errs = 0;
  int                          flow_errs = 0;
  int                          prop_errs;
  int                          seed;
  int                          draw;

  ct_fspu_top i_ct_fspu_top (
    .ex1_vld_clk            (ex1_vld_clk),
    .cpurst_b               (cpurst_b),
    .cp0_yy_clk_en          (cp0_yy_clk_en),
    .cp0_vfpu_icg_en        (cp0_vfpu_icg_en),
    .pad_yy_icg_scan_en     (pad_yy_icg_scan_en),
    .dp_vfalu_ex1_pipex_sel (dp_vfalu_ex1_pipex_sel),
    .dp_vfalu_ex1_op        (dp_vfalu_ex1_op),
    .dp_vfalu_ex1_src0      (dp_vfalu_ex1_src0),
    .dp_vfalu_ex1_src1      (dp_vfalu_ex1_src1),
    .ex3_pipedown           (ex3_pipedown),
    .fspu_ex3_result        (fspu_ex3_result)
  );

  // Pipedown and result checkers inside the top level
  bind ct_fspu_top ct_fspu_properties i_ct_fspu_properties (
    .ex1_vld_clk     (ex1_vld_clk),
    .cpurst_b        (cpurst_b),
    .ex1_pipedown    (ex1_pipedown),
    .ex2_pipedown    (ex2_pipedown),
    .ex3_pipedown    (ex3_pipedown),
    .fspu_ex3_result (fspu_ex3_result)
  );

  // Free-running pipe clock, period 4
  initial ex1_vld_clk = 1'b0;
  always #2 ex1_vld_clk = ~ex1_vld_clk;

  // Cycle count for latency checks
  always @(posedge ex1_vld_clk)
    cycle <= cycle + 1;

  // Readable op label for error lines
  function automatic string op_name(input ct_fspu_pkg::fspu_op_t op);
    case (op)
      `FSPU_OP_SGNJ:  op_name = "sgnj";
      `FSPU_OP_SGNJN: op_name = "sgnjn";
      `FSPU_OP_SGNJX: op_name = "sgnjx";
      `FSPU_OP_CLASS: op_name = "class";
      `FSPU_OP_MV:    op_name = "mv";
      default:        op_name = "unused";
    endcase
  endfunction

  // One vector onto the issue inputs
  task automatic issue_vector(input int idx);
    ct_fspu_pkg::fspu_pipe_sel_t sel;
    ct_fspu_pkg::fspu_op_t       op;
    sel = vec_mem[idx*VEC_WORDS][2:0];
    op  = vec_mem[idx*VEC_WORDS+1][2:0];
    @(posedge ex1_vld_clk);
    draw = $random(seed);
    dp_vfalu_ex1_pipex_sel <= sel;
    dp_vfalu_ex1_op        <= op;
    dp_vfalu_ex1_src0      <= vec_mem[idx*VEC_WORDS+2];
    dp_vfalu_ex1_src1      <= vec_mem[idx*VEC_WORDS+3];
    cp0_vfpu_icg_en        <= draw[0];
    // Only bit 0 owns this pipe; result expected in the cycle two later
    if (sel[0])
    begin
      exp_q.push_back(vec_mem[idx*VEC_WORDS+4]);
      name_q.push_back($sformatf("vec%0d_%s", idx, op_name(op)));
      cyc_q.push_back(cycle + 1);
    end
  endtask

  // Idle cycles with the pipe deselected
  task automatic idle_cycles(input int n);
    repeat (n)
    begin
      @(posedge ex1_vld_clk);
      draw = $random(seed);
      dp_vfalu_ex1_pipex_sel <= '0;
      cp0_vfpu_icg_en        <= draw[0];
    end
  endtask

  // Compare one presented result with the oldest expected entry
  task automatic check_result();
    ct_fspu_pkg::fspu_data_t exp_val;
    string                   name;
    int                      issued;
    exp_val = exp_q.pop_front();
    name    = name_q.pop_front();
    issued  = cyc_q.pop_front();
    assert (fspu_ex3_result === exp_val)
    else
    begin
      value_errs++;
      $display("Fail %s: expected 0x%08h, actual 0x%08h", name, exp_val, fspu_ex3_result);
    end
    assert (cycle - issued == LATENCY)
    else
    begin
      flow_errs++;
      $display("Fail %s latency: expected %0d, actual %0d", name, LATENCY, cycle - issued);
    end
  endtask

  // Outputs sampled mid-cycle where they are settled
  always @(negedge ex1_vld_clk)
  begin
    if (cpurst_b && ex3_pipedown)
    begin
      assert (exp_q.size() > 0)
      else
      begin
        flow_errs++;
        $display("Result 0x%08h came out at cycle %0d with no issue pending",
                 fspu_ex3_result, cycle);
      end
      if (exp_q.size() > 0)
        check_result();
    end
  end

  // Main sequence
  initial
  begin
    int gap;
    seed                   = 32'hfa8089b2;
    cpurst_b               = 1'b0;
    cp0_yy_clk_en          = 1'b1;
    cp0_vfpu_icg_en        = 1'b0;
    pad_yy_icg_scan_en     = 1'b0;
    dp_vfalu_ex1_pipex_sel = '0;
    dp_vfalu_ex1_op        = '0;
    dp_vfalu_ex1_src0      = '0;
    dp_vfalu_ex1_src1      = '0;
    $readmemh("verification/ct_fspu_vectors.txt", vec_mem);
    // Vector count ends at the first unfilled select word
    vec_cnt = 0;
    while (vec_cnt < MAX_VECS && !$isunknown(vec_mem[vec_cnt*VEC_WORDS]))
      vec_cnt++;
    vec_loaded = 1'b1;
    assert (vec_cnt > 0)
    else
    begin
      flow_errs++;
      $display("No vectors could be read from the vector file");
    end
    // Reset for two cycles
    repeat (2) @(posedge ex1_vld_clk);
    cpurst_b <= 1'b1;
    for (int i = 0; i < vec_cnt; i++)
    begin
      issue_vector(i);
      gap = {$random(seed)} % 4;
      idle_cycles(gap);
    end
    // Drain the pipe
    idle_cycles(LATENCY + 2);
    @(negedge ex1_vld_clk);
    assert (exp_q.size() == 0)
    else
    begin
      flow_errs++;
      $display("%0d issued operations never produced a result", exp_q.size());
    end
    prop_errs = i_ct_fspu_top.i_ct_fspu_properties.prop_errs;
    $display("Errors: value %0d, flow %0d, property %0d", value_errs, flow_errs, prop_errs);
    if (value_errs + flow_errs + prop_errs == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

  // Watchdog sized from the vector count
  initial
  begin
    wait (vec_loaded);
    #((vec_cnt * 8 + 20) * 4);
    $display("Run stopped by the watchdog at time %0t", $time);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/ct_fspu_vectors.txt
// Columns: pipe select, operation, src0, src1, expected result (hex)
// Expected result is ignored when select bit 0 is low
// Unselected issue before any work
2 0 3f800000 bf800000 00000000
// Sign inject plain
1 0 3f800000 bf800000 bf800000
1 0 bf800000 3f800000 3f800000
1 0 c0490fdb 00000000 40490fdb
1 0 7fc00000 80000000 ffc00000
1 0 00000000 ff800000 80000000
// Sign inject negated
1 1 3f800000 3f800000 bf800000
1 1 bf800000 bf800000 3f800000
1 1 80000000 00000000 80000000
1 1 7f800001 ffffffff 7f800001
1 1 ffc00000 7fc00000 ffc00000
4 3 7f800000 00000000 00000000
// Sign inject xor
1 2 bf800000 bf800000 3f800000
1 2 3f800000 bf800000 bf800000
1 2 40000000 40000000 40000000
1 2 ff800001 80000000 7f800001
1 2 80000000 00000000 80000000
// Classify, one line per class
1 3 ff800000 12345678 00000001
1 3 bf800000 12345678 00000002
1 3 80000001 12345678 00000004
1 3 80000000 12345678 00000008
1 3 00000000 12345678 00000010
1 3 007fffff 12345678 00000020
1 3 7f7fffff 12345678 00000040
1 3 7f800000 12345678 00000080
1 3 7f800001 12345678 00000100
1 3 7fc00000 12345678 00000200
1 3 ffbfffff 12345678 00000100
1 3 ffffffff 12345678 00000200
6 4 deadbeef 00000000 00000000
// Move
1 4 deadbeef 00000000 deadbeef
1 4 7fc00001 ffffffff 7fc00001
// Unused codes
1 5 3f800000 bf800000 00000000
1 6 7f800000 ffffffff 00000000
1 7 deadbeef 12345678 00000000
0 4 cafef00d 00000000 00000000
// Sibling select bits set alongside bit 0
3 4 cafef00d 00000000 cafef00d
7 2 c0000000 c0000000 40000000
5 0 12345678 80000000 92345678

//--- ct_fspu.f
+incdir+include
source/ct_fspu_pkg.sv
source/gated_clk_cell.sv
source/ct_fspu_ctrl.sv
source/ct_fspu_dp.sv
source/ct_fspu_top.sv
verification/ct_fspu_properties.sv
verification/ct_fspu_tb.sv

//--- Bender.yml
package:
  name: ct_fspu

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/ct_fspu_pkg.sv
      - source/gated_clk_cell.sv
      - source/ct_fspu_ctrl.sv
      - source/ct_fspu_dp.sv
      - source/ct_fspu_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/ct_fspu_properties.sv
      - verification/ct_fspu_tb.sv
